// ==== Bender.yml ====
package:
  name: mul_unit

sources:
  - verilog/mul_pkg.sv
  - verilog/booth_encoder.sv
  - verilog/booth_multiplier.sv
  - verilog/mul_cfg_regs.sv
  - verilog/mul_req_ctrl.sv
  - verilog/mul_unit_top.sv
  - target: test
    files:
      - testbench/tb_mul_unit.sv

// ==== build.f ====
verilog/mul_pkg.sv
verilog/booth_encoder.sv
verilog/booth_multiplier.sv
verilog/mul_cfg_regs.sv
verilog/mul_req_ctrl.sv
verilog/mul_unit_top.sv
testbench/tb_mul_unit.sv

// ==== testbench/tb_mul_unit.sv ====
`timescale 1ns/1ps

module tb_mul_unit;

	logic                clk;
	logic                rst;
	logic                req;
	logic                ack;
	mul_pkg::dword_t     multiplicand;
	mul_pkg::dword_t     multiplier;
	mul_pkg::dword_t     result_hi;
	mul_pkg::dword_t     result_lo;
	logic                cfg_wen;
	mul_pkg::cfg_addr_t  cfg_addr;
	mul_pkg::dword_t     cfg_wdata;
	mul_pkg::dword_t     cfg_rdata;

	// expected product of the request in flight
	mul_pkg::prod_t      exp_prod;
	// mode as last written into the DUT
	mul_pkg::sign_mode_t cur_sm;
	logic                cur_wm;
	integer              seed;
	int                  errors;
	int                  completed;
	int                  tests;
	mul_pkg::dword_t     rd;

	mul_unit_top mul_unit_top_i (.*);

	always #50 clk = ~clk;

	//**************************************************
	// reference model
	//**************************************************
	function automatic mul_pkg::prod_t ref_product(
		input mul_pkg::dword_t     a,
		input mul_pkg::dword_t     b,
		input mul_pkg::sign_mode_t sm,
		input logic                wm
	);
		mul_pkg::prod_t ea;
		mul_pkg::prod_t eb;
		mul_pkg::prod_t p;
		if (wm) begin
			// word operands come from the low 32 bits
			ea = sm[1] ? {{96{a[31]}}, a[31:0]} : {96'b0, a[31:0]};
			eb = sm[0] ? {{96{b[31]}}, b[31:0]} : {96'b0, b[31:0]};
			p  = ea * eb;
			return {{96{p[31]}}, p[31:0]};
		end
		ea = sm[1] ? {{64{a[63]}}, a} : {64'b0, a};
		eb = sm[0] ? {{64{b[63]}}, b} : {64'b0, b};
		return ea * eb;
	endfunction

	function automatic mul_pkg::dword_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// product compared on every cycle that ack is high
	always @(posedge clk) begin
		if (ack) begin
			if (result_hi !== exp_prod[127:64] || result_lo !== exp_prod[63:0]) begin
				$display("ERROR %0t: product %h_%h, expected %h", $time, result_hi,
					result_lo, exp_prod);
				errors++;
			end
		end
	end

	task automatic stop_on_timeout(input string what);
		$display("timed out after 200 cycles waiting for %s", what);
		$display("Something failed");
		$finish;
	endtask

	// combinational read sampled one edge after the address is driven
	task automatic read_cfg(input mul_pkg::cfg_addr_t addr, output mul_pkg::dword_t val);
		@(posedge clk);
		cfg_addr <= addr;
		@(posedge clk);
		val = cfg_rdata;
	endtask

	task automatic write_mode(input mul_pkg::sign_mode_t sm, input logic wm);
		mul_pkg::dword_t val;
		@(posedge clk);
		cfg_wen   <= 1'b1;
		cfg_addr  <= mul_pkg::cfg_addr_mode;
		cfg_wdata <= mul_pkg::dword_t'({wm, sm});
		@(posedge clk);
		cfg_wen   <= 1'b0;
		cur_sm = sm;
		cur_wm = wm;
		// mode reads back zero-extended
		read_cfg(mul_pkg::cfg_addr_mode, val);
		if (val !== mul_pkg::dword_t'({wm, sm})) begin
			$display("ERROR %0t: mode read %h, expected %h", $time, val, {wm, sm});
			errors++;
		end
	endtask

	// raise req with the expected result already set up
	task automatic issue(input mul_pkg::dword_t a, input mul_pkg::dword_t b);
		exp_prod = ref_product(a, b, cur_sm, cur_wm);
		@(posedge clk);
		multiplicand <= a;
		multiplier   <= b;
		req          <= 1'b1;
	endtask

	task automatic finish_op(input int hold);
		int n;
		n = 0;
		while (!ack && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (!ack)
			stop_on_timeout("ack to rise");
		// req held high for a while as back-pressure
		repeat (hold) begin
			@(posedge clk);
			if (!ack) begin
				$display("ERROR %0t: ack fell while req was still high", $time);
				errors++;
			end
		end
		req <= 1'b0;
		n = 0;
		while (ack && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (ack)
			stop_on_timeout("ack to fall");
		completed++;
	endtask

	task automatic mul(input mul_pkg::dword_t a, input mul_pkg::dword_t b);
		issue(a, b);
		finish_op(1 + ($unsigned($random(seed)) % 10));
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished, %0d errors so far", tests, name, errors);
	endtask

	//**************************************************
	// stimulus
	//**************************************************
	initial begin
		seed         = 68656;
		errors       = 0;
		completed    = 0;
		tests        = 0;
		clk          = 1'b0;
		rst          = 1'b1;
		req          = 1'b0;
		multiplicand = '0;
		multiplier   = '0;
		cfg_wen      = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		cur_sm       = '0;
		cur_wm       = 1'b0;
		exp_prod     = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// reset values
		read_cfg(mul_pkg::cfg_addr_mode, rd);
		if (ack !== 1'b0 || rd !== '0) begin
			$display("ERROR %0t: ack %b, mode %h after reset", $time, ack, rd);
			errors++;
		end
		read_cfg(mul_pkg::cfg_addr_count, rd);
		if (rd !== '0) begin
			$display("ERROR %0t: count %0d after reset", $time, rd);
			errors++;
		end
		end_test("reset values");

		repeat (20) mul(rand64(), rand64());
		mul('1, '1);
		mul('0, rand64());
		end_test("unsigned full mode");

		for (int m = 0; m < 4; m++) begin
			write_mode(mul_pkg::sign_mode_t'(m), 1'b0);
			// 4 times -6
			mul(64'd4, -64'sd6);
			mul(64'h8000_0000_0000_0000, '1);
			mul(64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
			mul('1, '1);
			repeat (4) mul(rand64(), rand64());
		end
		end_test("sign modes");

		// upper halves hold junk that word mode ignores
		for (int m = 0; m < 4; m++) begin
			write_mode(mul_pkg::sign_mode_t'(m), 1'b1);
			mul(64'hdead_beef_8000_0000, 64'h1234_5678_ffff_ffff);
			mul(64'h0000_0000_7fff_ffff, 64'hffff_ffff_7fff_ffff);
			mul(64'd4, -64'sd6);
			repeat (4) mul(rand64(), rand64());
		end
		end_test("word mode");

		// write lands after the controller latched the old mode
		write_mode(2'b00, 1'b0);
		issue('1, 64'd3);
		write_mode(2'b11, 1'b1);
		finish_op(2);
		mul('1, 64'd3);
		end_test("mode write in flight");

		read_cfg(mul_pkg::cfg_addr_count, rd);
		if (rd !== mul_pkg::dword_t'(completed)) begin
			$display("ERROR %0t: count %0d, expected %0d", $time, rd, completed);
			errors++;
		end
		end_test("handshake and count");

		$display("tests %0d, multiplies %0d, errors %0d", tests, completed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== verilog/booth_encoder.sv ====
`timescale 1ns/1ps

module booth_encoder (
	input  logic [2:0]                window,
	input  mul_pkg::ext_t             mcand,
	output logic [mul_pkg::xlen+3:0]  pp
);

	// multiplicand sign-extended to partial product width
	logic [mul_pkg::xlen+3:0] m1;
	// twice the multiplicand
	logic [mul_pkg::xlen+3:0] m2;
	// negated forms, invert plus one
	logic [mul_pkg::xlen+3:0] m1_neg;
	logic [mul_pkg::xlen+3:0] m2_neg;

	assign m1 = {{2{mcand[mul_pkg::xlen+1]}}, mcand};
	assign m2 = {m1[mul_pkg::xlen+2:0], 1'b0};

	assign m1_neg = ~m1 + 1'b1;
	assign m2_neg = ~m2 + 1'b1;

	// window is {q[i+1], q[i], q[i-1]}
	always_comb begin
		case (window)
			// runs of equal bits add nothing
			3'b000,
			3'b111: begin
				pp = '0;
			end
			3'b001,
			3'b010: begin
				pp = m1;
			end
			3'b011: begin
				pp = m2;
			end
			3'b100: begin
				pp = m2_neg;
			end
			// 101 and 110
			default: begin
				pp = m1_neg;
			end
		endcase
	end

endmodule

// ==== verilog/booth_multiplier.sv ====
`timescale 1ns/1ps

module booth_multiplier (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  mul_pkg::dword_t     mcand,
	input  mul_pkg::dword_t     mplier,
	input  mul_pkg::sign_mode_t sign_mode,
	input  logic                word_mode,
	output logic                busy,
	output logic                done,
	output mul_pkg::prod_t      product
);

	// sign or zero extension into the 66-bit working width
	// word mode takes bit 31 as the top of the operand
	function automatic mul_pkg::ext_t extend(
		input mul_pkg::dword_t v,
		input logic            sgn,
		input logic            word
	);
		logic top;
		top = sgn & (word ? v[31] : v[mul_pkg::xlen-1]);
		if (word)
			return {{34{top}}, v[31:0]};
		return {{2{top}}, v};
	endfunction

	//**************************************************
	// working registers
	//**************************************************
	// partial sum, upper part of the combined register
	logic [mul_pkg::xlen+3:0] acc;
	// multiplier bits, product low bits shift in from the top
	mul_pkg::ext_t            mq;
	// bit to the right of the current window
	logic                     q_low;
	mul_pkg::ext_t            mcand_q;
	logic                     word_q;
	mul_pkg::step_t           cnt;

	logic [mul_pkg::xlen+3:0] pp;
	logic [mul_pkg::xlen+3:0] sum;
	logic                     accept;

	assign busy   = (cnt != '0);
	// new start only from idle
	assign accept = start & ~busy;

	booth_encoder booth_encoder_i (
		.window (({mq[1:0], q_low})),
		.mcand  (mcand_q),
		.pp     (pp)
	);

	assign sum = acc + pp;

	// step counter and done pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				cnt <= word_mode ? mul_pkg::word_steps : mul_pkg::full_steps;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				// last step, result in registers next cycle
				if (cnt == mul_pkg::step_t'(1))
					done <= 1'b1;
			end
		end
	end

	// datapath, load then add and shift
	always_ff @(posedge clk) begin
		if (accept) begin
			acc     <= '0;
			mq      <= extend(mplier, sign_mode[0], word_mode);
			q_low   <= 1'b0;
			mcand_q <= extend(mcand, sign_mode[1], word_mode);
			word_q  <= word_mode;
		end else if (busy) begin
			// arithmetic shift right by two of {sum, mq, q_low}
			acc   <= {{2{sum[mul_pkg::xlen+3]}}, sum[mul_pkg::xlen+3:2]};
			mq    <= {sum[1:0], mq[mul_pkg::xlen+1:2]};
			q_low <= mq[1];
		end
	end

	//**************************************************
	// result shaping
	//**************************************************
	// full mode: 128 bits straight from {acc, mq}
	// word mode: only 34 bits shifted in, low product word sits in mq[63:32]
	always_comb begin
		if (word_q) begin
			product = {{(mul_pkg::xlen+32){mq[63]}}, mq[63:32]};
		end else begin
			product = {acc[mul_pkg::xlen-3:0], mq};
		end
	end

endmodule

// ==== verilog/mul_cfg_regs.sv ====
`timescale 1ns/1ps

module mul_cfg_regs (
	input  logic                clk,
	input  logic                rst,
	input  logic                cfg_wen,
	input  mul_pkg::cfg_addr_t  cfg_addr,
	input  mul_pkg::dword_t     cfg_wdata,
	output mul_pkg::dword_t     cfg_rdata,
	input  logic                op_done,
	output mul_pkg::sign_mode_t sign_mode,
	output logic                word_mode
);

	// completed multiplies, wraps
	mul_pkg::cnt_t count;

	logic mode_wen;

	assign mode_wen = cfg_wen & (cfg_addr == mul_pkg::cfg_addr_mode);

	//**************************************************
	// mode register
	//**************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			// unsigned, full width
			sign_mode <= '0;
			word_mode <= 1'b0;
		end else if (mode_wen) begin
			sign_mode <= cfg_wdata[1:0];
			word_mode <= cfg_wdata[2];
		end
	end

	// count register ignores writes
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (op_done) begin
			count <= count + 1'b1;
		end
	end

	//**************************************************
	// read mux
	//**************************************************
	always_comb begin
		case (cfg_addr)
			mul_pkg::cfg_addr_mode: begin
				cfg_rdata = mul_pkg::dword_t'({word_mode, sign_mode});
			end
			mul_pkg::cfg_addr_count: begin
				cfg_rdata = mul_pkg::dword_t'(count);
			end
			// unmapped addresses
			default: begin
				cfg_rdata = '0;
			end
		endcase
	end

endmodule

// ==== verilog/mul_pkg.sv ====
package mul_pkg;

	//**************************************************
	// widths
	//**************************************************
	localparam int xlen = 64;

	typedef logic [xlen-1:0]   dword_t;
	// two extra bits so the radix-4 windows cover the sign
	typedef logic [xlen+1:0]   ext_t;
	typedef logic [2*xlen-1:0] prod_t;
	// [1] multiplicand signed, [0] multiplier signed
	typedef logic [1:0]        sign_mode_t;
	typedef logic [1:0]        cfg_addr_t;
	typedef logic [31:0]       cnt_t;
	typedef logic [5:0]        step_t;

	//**************************************************
	// configuration map
	//**************************************************
	// mode register: sign mode in 1:0, word mode in 2
	localparam cfg_addr_t cfg_addr_mode  = 2'd0;
	// completed multiplies, read only
	localparam cfg_addr_t cfg_addr_count = 2'd1;

	// radix-4 steps, 66-bit and 34-bit extended operands
	localparam step_t full_steps = 6'd33;
	localparam step_t word_steps = 6'd17;

	// request controller
	typedef enum logic [1:0] {st_idle, st_run, st_hold, st_drop} ctrl_state_t;

endpackage

// ==== verilog/mul_req_ctrl.sv ====
`timescale 1ns/1ps

module mul_req_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	output logic                ack,
	input  mul_pkg::dword_t     multiplicand,
	input  mul_pkg::dword_t     multiplier,
	input  mul_pkg::sign_mode_t sign_mode,
	input  logic                word_mode,
	output logic                start,
	output mul_pkg::dword_t     mcand,
	output mul_pkg::dword_t     mplier,
	output mul_pkg::sign_mode_t sign_mode_q,
	output logic                word_mode_q,
	input  logic                done,
	input  mul_pkg::prod_t      product,
	output mul_pkg::dword_t     result_hi,
	output mul_pkg::dword_t     result_lo,
	output logic                op_done
);

	mul_pkg::ctrl_state_t state;

	logic take;

	// request accepted this cycle
	assign take = (state == mul_pkg::st_idle) & req;

	// operands and mode frozen for the whole multiply
	always_ff @(posedge clk) begin
		if (take) begin
			mcand       <= multiplicand;
			mplier      <= multiplier;
			sign_mode_q <= sign_mode;
			word_mode_q <= word_mode;
		end
	end

	//**************************************************
	// four-phase handshake FSM
	//**************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= mul_pkg::st_idle;
			start     <= 1'b0;
			ack       <= 1'b0;
			op_done   <= 1'b0;
			result_hi <= '0;
			result_lo <= '0;
		end else begin
			// single-cycle pulses
			start   <= 1'b0;
			op_done <= 1'b0;
			case (state)
				mul_pkg::st_idle: begin
					if (req) begin
						start <= 1'b1;
						state <= mul_pkg::st_run;
					end
				end
				mul_pkg::st_run: begin
					// product only valid with done
					if (done) begin
						result_hi <= product[2*mul_pkg::xlen-1:mul_pkg::xlen];
						result_lo <= product[mul_pkg::xlen-1:0];
						ack       <= 1'b1;
						op_done   <= 1'b1;
						state     <= mul_pkg::st_hold;
					end
				end
				mul_pkg::st_hold: begin
					// result held as long as req stays high
					if (!req)
						state <= mul_pkg::st_drop;
				end
				default: begin
					// st_drop, ack falls one cycle after req
					ack   <= 1'b0;
					state <= mul_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

// ==== verilog/mul_unit_top.sv ====
`timescale 1ns/1ps

module mul_unit_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	output logic               ack,
	input  mul_pkg::dword_t    multiplicand,
	input  mul_pkg::dword_t    multiplier,
	output mul_pkg::dword_t    result_hi,
	output mul_pkg::dword_t    result_lo,
	input  logic               cfg_wen,
	input  mul_pkg::cfg_addr_t cfg_addr,
	input  mul_pkg::dword_t    cfg_wdata,
	output mul_pkg::dword_t    cfg_rdata
);

	// live mode from the register block
	mul_pkg::sign_mode_t sign_mode;
	logic                word_mode;
	logic                op_done;

	// controller to datapath
	logic                start;
	mul_pkg::dword_t     mcand;
	mul_pkg::dword_t     mplier;
	mul_pkg::sign_mode_t sign_mode_q;
	logic                word_mode_q;
	logic                done;
	mul_pkg::prod_t      product;

	//**************************************************
	// instances
	//**************************************************
	mul_cfg_regs mul_cfg_regs_i (
		.clk       (clk),
		.rst       (rst),
		.cfg_wen   (cfg_wen),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.op_done   (op_done),
		.sign_mode (sign_mode),
		.word_mode (word_mode)
	);

	mul_req_ctrl mul_req_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.ack          (ack),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.sign_mode    (sign_mode),
		.word_mode    (word_mode),
		.start        (start),
		.mcand        (mcand),
		.mplier       (mplier),
		.sign_mode_q  (sign_mode_q),
		.word_mode_q  (word_mode_q),
		.done         (done),
		.product      (product),
		.result_hi    (result_hi),
		.result_lo    (result_lo),
		.op_done      (op_done)
	);

	// busy only gates start inside the datapath
	booth_multiplier booth_multiplier_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.mcand     (mcand),
		.mplier    (mplier),
		.sign_mode (sign_mode_q),
		.word_mode (word_mode_q),
		.busy      (),
		.done      (done),
		.product   (product)
	);

endmodule
